/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary -j 0
TOP       = tb_decode_stage
FILELIST  = loong_decode.f
OBJ_DIR   = obj_dir
LOG       = sim.log

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) hw/decode_consts.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/decode_vectors.txt */
// first word is the vector count, then one vector per line:
// inst pc we wa ra1 ra2 re1 re2 aluop alusel imm is_exception
0000001c
00100c41 1c000000 1 01 02 03 1 1 01 1 00000000 0
001118a4 1c000004 1 04 05 06 1 1 02 1 00000000 0
00122507 1c000008 1 07 08 09 1 1 03 1 00000000 0
0012b16a 1c00000c 1 0a 0b 0c 1 1 04 1 00000000 0
00143dcd 1c000010 1 0d 0e 0f 1 1 08 2 00000000 0
0014ca30 1c000014 1 10 11 12 1 1 05 2 00000000 0
00155693 1c000018 1 13 14 15 1 1 06 2 00000000 0
0015e2f6 1c00001c 1 16 17 18 1 1 07 2 00000000 0
00176f59 1c000020 1 19 1a 1b 1 1 09 3 00000000 0
0017fbbc 1c000024 1 1c 1d 1e 1 1 0a 3 00000000 0
00187c1f 1c000028 1 1f 00 1f 1 1 0b 3 00000000 0
// 2RI12, bit 21 set in the signed and unsigned forms
02200043 1c00002c 1 03 02 00 1 0 03 1 fffff800 0
02048c85 1c000030 1 05 04 00 1 0 03 1 00000123 0
027ffcc7 1c000034 1 07 06 00 1 0 04 1 ffffffff 0
02a96909 1c000038 1 09 08 00 1 0 01 1 fffffa5a 0
029ffc21 1c00003c 1 01 01 00 1 0 01 1 000007ff 0
0360014b 1c000040 1 0b 0a 00 1 0 05 2 00000800 0
03bffd8d 1c000044 1 0d 0c 00 1 0 06 2 00000fff 0
03e6adcf 1c000048 1 0f 0e 00 1 0 07 2 000009ab 0
// 1RI20
142468a1 1c00004c 1 01 00 00 0 0 0c 1 12345000 0
15ffffff 1c000050 1 1f 00 00 0 0 0c 1 fffff000 0
1c000024 1c000054 1 04 00 00 0 0 0d 1 00001000 0
1d000005 1c000058 1 05 00 00 0 0 0d 1 80000000 0
// undefined words
00000000 1c00005c 0 00 00 00 0 0 00 0 00000000 1
ffffffff 1c000060 0 00 00 00 0 0 00 0 00000000 1
00108000 1c000064 0 00 00 00 0 0 00 0 00000000 1
03000000 1c000068 0 00 00 00 0 0 00 0 00000000 1
18000000 1c00006c 0 00 00 00 0 0 00 0 00000000 1

/* bench/tb_decode_stage.sv */
`include "decode_consts.svh"

module tb_decode_stage
    import decode_pkg::*;
();

    localparam int COLS = 12;
    localparam int MAX_VEC = 64;

    logic          clk;
    logic          reset;
    logic          stall;
    logic          flush;
    fetch_t        fetch_in;
    decoded_inst_t dec_out;
    decoded_inst_t prev_out;

    logic [31:0] vec_mem [0:MAX_VEC*COLS];
    logic [31:0] rng;
    int          num_vec;
    int          checks;
    int          errors;
    int          slot_in;    // vector index in fetch_q or -1
    int          slot_out;   // vector index on dec_out or -1
    int          drv_idx;    // vector index on fetch_in or -1
    int          next_idx;
    logic        held;       // last edge was a stall

    decode_stage DUT (
        .clk     (clk),
        .reset   (reset),
        .stall   (stall),
        .flush   (flush),
        .fetch_in(fetch_in),
        .dec_out (dec_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] vec_field(input int idx, input int col);
        return vec_mem[1 + idx * COLS + col];
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_output();
        if (held) begin
            checks++;
            assert (dec_out === prev_out) else begin
                $display("dec_out changed while stall was high");
                errors++;
            end
        end
        compare_field("dec_out.valid", 32'(dec_out.valid), 32'(slot_out >= 0));
        if (slot_out >= 0) begin
            compare_field("dec_out.inst", dec_out.inst, vec_field(slot_out, 0));
            compare_field("dec_out.pc", dec_out.pc, vec_field(slot_out, 1));
            compare_field("dec_out.reg_write_en", 32'(dec_out.reg_write_en),
                          vec_field(slot_out, 2));
            compare_field("dec_out.reg_write_addr", 32'(dec_out.reg_write_addr),
                          vec_field(slot_out, 3));
            compare_field("dec_out.reg1_read_addr", 32'(dec_out.reg1_read_addr),
                          vec_field(slot_out, 4));
            compare_field("dec_out.reg2_read_addr", 32'(dec_out.reg2_read_addr),
                          vec_field(slot_out, 5));
            compare_field("dec_out.reg1_read_en", 32'(dec_out.reg1_read_en),
                          vec_field(slot_out, 6));
            compare_field("dec_out.reg2_read_en", 32'(dec_out.reg2_read_en),
                          vec_field(slot_out, 7));
            compare_field("dec_out.aluop", 32'(dec_out.aluop), vec_field(slot_out, 8));
            compare_field("dec_out.alusel", 32'(dec_out.alusel), vec_field(slot_out, 9));
            compare_field("dec_out.imm", dec_out.imm, vec_field(slot_out, 10));
            compare_field("dec_out.is_exception", 32'(dec_out.is_exception),
                          vec_field(slot_out, 11));
            compare_field("dec_out.exception_cause", 32'(dec_out.exception_cause),
                          vec_field(slot_out, 11) != 0 ? 32'(`EXCEPTION_INE) : 32'h0);
        end
        prev_out = dec_out;
    endtask

    // update the model on the rising edge and check on the falling one
    task automatic clock_edge();
        @(posedge clk);
        held = stall && !flush && !reset;
        if (reset || flush) begin
            slot_in = -1;
            slot_out = -1;
        end else if (!stall) begin
            slot_out = slot_in;
            slot_in = drv_idx;
            if (drv_idx >= 0) begin
                next_idx++;
            end
        end
        @(negedge clk);
        check_output();
    endtask

    task automatic drive_vector(input int idx);
        fetch_in.valid = 1'b1;
        fetch_in.pc = vec_field(idx, 1);
        fetch_in.inst = vec_field(idx, 0);
        drv_idx = idx;
    endtask

    task automatic drive_bubble();
        fetch_in = '0;
        drv_idx = -1;
    endtask

    // stray word offered while stalled
    task automatic drive_decoy(input logic [31:0] r);
        fetch_in.valid = 1'b1;
        fetch_in.pc = ~r;
        fetch_in.inst = r;
        drv_idx = -1;
    endtask

    task automatic report_test(input string name, input int c0, input int e0);
        $display("test %s: %0d checks, %0d errors", name, checks - c0, errors - e0);
    endtask

    initial begin
        int c0;
        int e0;
        int stalls;
        int flushes;
        logic [7:0] pick;
        reset = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        fetch_in = '0;
        prev_out = '0;
        rng = 32'hc6e8;
        checks = 0;
        errors = 0;
        slot_in = -1;
        slot_out = -1;
        drv_idx = -1;
        held = 1'b0;
        stalls = 0;
        flushes = 0;
        $readmemh("bench/decode_vectors.txt", vec_mem);
        num_vec = int'(vec_mem[0]);
        if (num_vec < 1 || num_vec > MAX_VEC) begin
            $display("vector file is missing or holds a bad vector count");
            errors++;
            num_vec = 0;
        end

        c0 = checks;
        e0 = errors;
        repeat (5) clock_edge();
        reset = 1'b0;
        repeat (4) clock_edge();
        report_test("reset_idle", c0, e0);

        c0 = checks;
        e0 = errors;
        next_idx = 0;
        while (next_idx < num_vec) begin
            drive_vector(next_idx);
            clock_edge();
        end
        drive_bubble();
        repeat (2) clock_edge();
        report_test("decode_sweep", c0, e0);

        c0 = checks;
        e0 = errors;
        next_idx = 0;
        while (next_idx < 2 * num_vec) begin
            rng = lcg_next(rng);
            pick = rng[31:24];
            stall = 1'b0;
            flush = 1'b0;
            if (pick < 8'd20) begin
                flush = 1'b1;
                stall = rng[16];    // flush has to beat stall
                flushes++;
                drive_vector(next_idx % num_vec);
            end else if (pick < 8'd64) begin
                stall = 1'b1;
                stalls++;
                drive_decoy(lcg_next(rng));
            end else if (pick < 8'd100) begin
                drive_bubble();
            end else begin
                drive_vector(next_idx % num_vec);
            end
            clock_edge();
        end
        stall = 1'b0;
        flush = 1'b0;
        drive_bubble();
        repeat (2) clock_edge();
        checks++;
        assert (num_vec == 0 || (stalls > 0 && flushes > 0)) else begin
            $display("random traffic never stalled or never flushed the stage");
            errors++;
        end
        report_test("random_traffic", c0, e0);

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // about 20 cycles per vector is far more than both passes need
    initial begin
        int limit;
        #1;
        limit = num_vec * 20 + 100;
        repeat (limit) @(posedge clk);
        $display("timeout after %0d cycles, the run did not finish", limit);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* hw/decode_consts.svh */
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// 3R opcodes, compared against inst[31:15]
`define ADD_W_OPCODE        17'h00020
`define SUB_W_OPCODE        17'h00022
`define SLT_OPCODE          17'h00024
`define SLTU_OPCODE         17'h00025
`define NOR_OPCODE          17'h00028
`define AND_OPCODE          17'h00029
`define OR_OPCODE           17'h0002a
`define XOR_OPCODE          17'h0002b
`define SLL_W_OPCODE        17'h0002e
`define SRL_W_OPCODE        17'h0002f
`define SRA_W_OPCODE        17'h00030

// 2RI12 opcodes, inst[31:22]
`define SLTI_OPCODE         10'h008
`define SLTUI_OPCODE        10'h009
`define ADDI_W_OPCODE       10'h00a
`define ANDI_OPCODE         10'h00d
`define ORI_OPCODE          10'h00e
`define XORI_OPCODE         10'h00f

// 1RI20 opcodes, inst[31:25]
`define LU12I_W_OPCODE      7'h0a
`define PCADDU12I_OPCODE    7'h0e

`define ALU_NOP             8'h00
`define ALU_ADD             8'h01
`define ALU_SUB             8'h02
`define ALU_SLT             8'h03
`define ALU_SLTU            8'h04
`define ALU_AND             8'h05
`define ALU_OR              8'h06
`define ALU_XOR             8'h07
`define ALU_NOR             8'h08
`define ALU_SLL             8'h09
`define ALU_SRL             8'h0a
`define ALU_SRA             8'h0b
`define ALU_LUI             8'h0c
`define ALU_PCADDU12I       8'h0d   // pc + imm done in the alu

`define ALU_SEL_NOP         3'b000
`define ALU_SEL_ARITHMETIC  3'b001
`define ALU_SEL_LOGIC       3'b010
`define ALU_SEL_SHIFT       3'b011

`define EXCEPTION_INE       7'h0d   // instruction not exist

`endif

/* hw/decode_pkg.sv */
package decode_pkg;

    // word coming out of fetch
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_t;

    // full decode record handed to the next stage
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
        logic        reg_write_en;
        logic [4:0]  reg_write_addr;
        logic        reg1_read_en;
        logic [4:0]  reg1_read_addr;
        logic        reg2_read_en;
        logic [4:0]  reg2_read_addr;
        logic [7:0]  aluop;
        logic [2:0]  alusel;
        logic [31:0] imm;
        logic        is_exception;
        logic [6:0]  exception_cause;
    } decoded_inst_t;

    // result of one format decoder, all zero on a miss
    typedef struct packed {
        logic        hit;
        logic        reg_write_en;
        logic        reg1_read_en;
        logic        reg2_read_en;
        logic [4:0]  reg1_read_addr;
        logic [4:0]  reg2_read_addr;
        logic [7:0]  aluop;
        logic [2:0]  alusel;
        logic [31:0] imm;
    } format_result_t;

endpackage

/* hw/decode_select.sv */
`include "decode_consts.svh"

module decode_select
    import decode_pkg::*;
(
    input  fetch_t         fetch,
    input  format_result_t r3,
    input  format_result_t ri12,
    input  format_result_t ri20,
    output decoded_inst_t  dec
);

    format_result_t pick;

    // opcode spaces are disjoint, at most one hit
    always_comb begin
        if (r3.hit) begin
            pick = r3;
        end else if (ri12.hit) begin
            pick = ri12;
        end else begin
            pick = ri20;        // all zero when nothing hits
        end
    end

    always_comb begin
        dec = '0;
        dec.valid = fetch.valid;
        dec.pc = fetch.pc;
        dec.inst = fetch.inst;
        dec.aluop = `ALU_NOP;
        dec.alusel = `ALU_SEL_NOP;
        if (fetch.valid && pick.hit) begin
            dec.reg_write_en = pick.reg_write_en;
            dec.reg_write_addr = fetch.inst[4:0];   // rd
            dec.reg1_read_en = pick.reg1_read_en;
            dec.reg1_read_addr = pick.reg1_read_addr;
            dec.reg2_read_en = pick.reg2_read_en;
            dec.reg2_read_addr = pick.reg2_read_addr;
            dec.aluop = pick.aluop;
            dec.alusel = pick.alusel;
            dec.imm = pick.imm;
        end else if (fetch.valid) begin
            dec.is_exception = 1'b1;
            dec.exception_cause = `EXCEPTION_INE;
        end
    end

endmodule

/* hw/decode_stage.sv */
module decode_stage
    import decode_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          stall,
    input  logic          flush,
    input  fetch_t        fetch_in,
    output decoded_inst_t dec_out
);

    fetch_t         fetch_q;
    format_result_t r3_res;
    format_result_t ri12_res;
    format_result_t ri20_res;
    decoded_inst_t  dec_d;

    stage_reg #(
        .payload_t(fetch_t)
    ) u_fetch_reg (
        .clk  (clk),
        .reset(reset),
        .stall(stall),
        .flush(flush),
        .d    (fetch_in),
        .q    (fetch_q)
    );

    // all three formats decode in parallel
    id_3r u_id_3r (
        .inst  (fetch_q.inst),
        .result(r3_res)
    );

    id_2ri12 u_id_2ri12 (
        .inst  (fetch_q.inst),
        .result(ri12_res)
    );

    id_1ri20 u_id_1ri20 (
        .inst  (fetch_q.inst),
        .result(ri20_res)
    );

    decode_select u_select (
        .fetch(fetch_q),
        .r3   (r3_res),
        .ri12 (ri12_res),
        .ri20 (ri20_res),
        .dec  (dec_d)
    );

    stage_reg #(
        .payload_t(decoded_inst_t)
    ) u_dec_reg (
        .clk  (clk),
        .reset(reset),
        .stall(stall),
        .flush(flush),
        .d    (dec_d),
        .q    (dec_out)
    );

endmodule

/* hw/id_1ri20.sv */
`include "decode_consts.svh"

module id_1ri20
    import decode_pkg::*;
(
    input  logic [31:0]    inst,
    output format_result_t result
);

    logic [6:0]  opcode;
    logic [19:0] i20;

    assign opcode = inst[31:25];
    assign i20 = inst[24:5];

    always_comb begin
        result = '0;
        result.hit = 1'b1;
        case (opcode)
            `LU12I_W_OPCODE: begin
                result.aluop = `ALU_LUI;
                result.alusel = `ALU_SEL_ARITHMETIC;
            end
            `PCADDU12I_OPCODE: begin
                result.aluop = `ALU_PCADDU12I;   // alu adds the pc
                result.alusel = `ALU_SEL_ARITHMETIC;
            end
            default: begin
                result.hit = 1'b0;
                result.aluop = `ALU_NOP;
                result.alusel = `ALU_SEL_NOP;
            end
        endcase
        // no register source in this format
        if (result.hit) begin
            result.reg_write_en = 1'b1;
            result.imm = {i20, 12'b0};
        end
    end

endmodule

/* hw/id_2ri12.sv */
`include "decode_consts.svh"

module id_2ri12
    import decode_pkg::*;
(
    input  logic [31:0]    inst,
    output format_result_t result
);

    logic [9:0]  opcode;
    logic [4:0]  rj;
    logic [11:0] i12;
    logic        sext;     // signed immediate forms

    assign opcode = inst[31:22];
    assign rj = inst[9:5];
    assign i12 = inst[21:10];

    always_comb begin
        result = '0;
        result.hit = 1'b1;
        sext = 1'b0;
        case (opcode)
            `SLTI_OPCODE: begin
                result.aluop = `ALU_SLT;
                result.alusel = `ALU_SEL_ARITHMETIC;
                sext = 1'b1;
            end
            `SLTUI_OPCODE: begin
                result.aluop = `ALU_SLTU;
                result.alusel = `ALU_SEL_ARITHMETIC;
                sext = 1'b1;       // sign extended, compared unsigned
            end
            `ADDI_W_OPCODE: begin
                result.aluop = `ALU_ADD;
                result.alusel = `ALU_SEL_ARITHMETIC;
                sext = 1'b1;
            end
            `ANDI_OPCODE: begin
                result.aluop = `ALU_AND;
                result.alusel = `ALU_SEL_LOGIC;
            end
            `ORI_OPCODE: begin
                result.aluop = `ALU_OR;
                result.alusel = `ALU_SEL_LOGIC;
            end
            `XORI_OPCODE: begin
                result.aluop = `ALU_XOR;
                result.alusel = `ALU_SEL_LOGIC;
            end
            default: begin
                result.hit = 1'b0;
                result.aluop = `ALU_NOP;
                result.alusel = `ALU_SEL_NOP;
            end
        endcase
        if (result.hit) begin
            result.reg_write_en = 1'b1;
            result.reg1_read_en = 1'b1;
            result.reg1_read_addr = rj;
            if (sext) begin
                result.imm = {{20{i12[11]}}, i12};
            end else begin
                result.imm = {20'b0, i12};
            end
        end
    end

endmodule

/* hw/id_3r.sv */
`include "decode_consts.svh"

module id_3r
    import decode_pkg::*;
(
    input  logic [31:0]    inst,
    output format_result_t result
);

    logic [16:0] opcode;
    logic [4:0]  rj;
    logic [4:0]  rk;

    assign opcode = inst[31:15];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    always_comb begin
        result = '0;
        result.hit = 1'b1;
        case (opcode)
            `ADD_W_OPCODE: begin
                result.aluop = `ALU_ADD;
                result.alusel = `ALU_SEL_ARITHMETIC;
            end
            `SUB_W_OPCODE: begin
                result.aluop = `ALU_SUB;
                result.alusel = `ALU_SEL_ARITHMETIC;
            end
            `SLT_OPCODE: begin
                result.aluop = `ALU_SLT;
                result.alusel = `ALU_SEL_ARITHMETIC;
            end
            `SLTU_OPCODE: begin
                result.aluop = `ALU_SLTU;
                result.alusel = `ALU_SEL_ARITHMETIC;
            end
            `AND_OPCODE: begin
                result.aluop = `ALU_AND;
                result.alusel = `ALU_SEL_LOGIC;
            end
            `OR_OPCODE: begin
                result.aluop = `ALU_OR;
                result.alusel = `ALU_SEL_LOGIC;
            end
            `XOR_OPCODE: begin
                result.aluop = `ALU_XOR;
                result.alusel = `ALU_SEL_LOGIC;
            end
            `NOR_OPCODE: begin
                result.aluop = `ALU_NOR;
                result.alusel = `ALU_SEL_LOGIC;
            end
            `SLL_W_OPCODE: begin
                result.aluop = `ALU_SLL;
                result.alusel = `ALU_SEL_SHIFT;
            end
            `SRL_W_OPCODE: begin
                result.aluop = `ALU_SRL;
                result.alusel = `ALU_SEL_SHIFT;
            end
            `SRA_W_OPCODE: begin
                result.aluop = `ALU_SRA;
                result.alusel = `ALU_SEL_SHIFT;
            end
            default: begin
                result.hit = 1'b0;
                result.aluop = `ALU_NOP;
                result.alusel = `ALU_SEL_NOP;
            end
        endcase
        if (result.hit) begin
            result.reg_write_en = 1'b1;     // rd always written
            result.reg1_read_en = 1'b1;
            result.reg2_read_en = 1'b1;
            result.reg1_read_addr = rj;
            result.reg2_read_addr = rk;
        end
    end

endmodule

/* hw/stage_reg.sv */
module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // flush beats stall, clearing drops valid with the rest
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

/* loong_decode.f */
+incdir+hw
hw/decode_pkg.sv
hw/stage_reg.sv
hw/id_3r.sv
hw/id_2ri12.sv
hw/id_1ri20.sv
hw/decode_select.sv
hw/decode_stage.sv
bench/tb_decode_stage.sv
